//--- source/wb_route_pkg.sv
//************************************************************
// Wishbone router package. Sizes, address map and enums.
//************************************************************
package wb_route_pkg;

  // Bus sizes.
  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;

  // Slave count and rules per slave.
  localparam int NUM_SLAVE = 3;
  localparam int NUM_RULES = 2;
  localparam int SLV_IDX_W = 2;

  // Request FIFO sizing.
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // One FIFO entry holds opcode, address and write data.
  localparam int REQ_W = 1 + ADDR_W + DATA_W;

  // Base addresses, indexed [slave][rule].
  localparam logic [NUM_SLAVE-1:0][NUM_RULES-1:0][ADDR_W-1:0] RULE_BASE = {
    16'hC000, 16'h8000,   // Slave 2, rule 1 then rule 0.
    16'h2000, 16'h4000,   // Slave 1.
    16'h1000, 16'h0000    // Slave 0.
  };

  // Masks, same shape. A set bit takes part in the compare.
  localparam logic [NUM_SLAVE-1:0][NUM_RULES-1:0][ADDR_W-1:0] RULE_MASK = {
    16'hF000, 16'hC000,
    16'hF000, 16'hC000,
    16'hF000, 16'hF000
  };

  // Request opcode as stored in the FIFO.
  typedef enum logic {OP_READ = 1'b0, OP_WRITE = 1'b1} wb_op_e;

  // Upstream port states.
  typedef enum logic [1:0] {US_IDLE, US_ACK, US_WAIT_RSP} up_state_e;

  // Dispatcher states.
  typedef enum logic {DS_IDLE, DS_CYCLE} disp_state_e;

endpackage

//--- source/wb_addr_resolver.sv
//************************************************************
// Address resolver. Matches an address against the rule
// table and returns the index of the slave that hit.
//************************************************************
`timescale 1ns/1ps

module wb_addr_resolver import wb_route_pkg::*; (
  input  logic [ADDR_W-1:0]    addr_i,
  output logic [SLV_IDX_W-1:0] match_idx_o,
  output logic                 match_ok_o
);

  // One bit per rule, then one bit per slave.
  logic [NUM_SLAVE-1:0][NUM_RULES-1:0] rule_hit;
  logic [NUM_SLAVE-1:0]                slave_hit;

  for (genvar i = 0; i < NUM_SLAVE; i++) begin : g_slave
    for (genvar j = 0; j < NUM_RULES; j++) begin : g_rule
      // Address and base must agree on every masked bit.
      assign rule_hit[i][j] = ((addr_i ^ RULE_BASE[i][j]) & RULE_MASK[i][j]) == '0;
    end

    // A slave hits when any of its rules hits.
    assign slave_hit[i] = |rule_hit[i];
  end

  // Any slave hit means the address is mapped.
  assign match_ok_o = |slave_hit;

  // Lowest matching slave wins.
  // Rules are exclusive, so this only matters if the table is broken.
  always_comb begin
    match_idx_o = '0;
    for (int i = NUM_SLAVE - 1; i >= 0; i--) begin
      if (slave_hit[i]) begin
        match_idx_o = SLV_IDX_W'(i);
      end
    end
  end

endmodule

//--- source/wb_upstream_port.sv
//************************************************************
// Upstream Wishbone port. Queues requests, posts writes and
// holds reads until their response returns.
//************************************************************
`timescale 1ns/1ps

module wb_upstream_port import wb_route_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  // Wishbone classic slave side.
  input  logic              s_cyc_i,
  input  logic              s_stb_i,
  input  logic              s_we_i,
  input  logic [ADDR_W-1:0] s_adr_i,
  input  logic [DATA_W-1:0] s_dat_i,
  output logic              s_ack_o,
  output logic              s_err_o,
  output logic [DATA_W-1:0] s_dat_o,
  // Request FIFO push side.
  output logic              push_o,
  output logic [REQ_W-1:0]  push_data_o,
  input  logic              full_i,
  // Read response from the dispatcher.
  input  logic              rsp_valid_i,
  input  logic              rsp_err_i,
  input  logic [DATA_W-1:0] rsp_data_i
);

  up_state_e state;
  wb_op_e    req_op;
  logic      req_take;

  // Opcode of the request on the bus.
  assign req_op = s_we_i ? OP_WRITE : OP_READ;

  // Request accepted only when idle and the FIFO has room.
  assign req_take = (state == US_IDLE) && s_cyc_i && s_stb_i && !full_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state   <= US_IDLE;
      push_o  <= 1'b0;
      s_ack_o <= 1'b0;
      s_err_o <= 1'b0;
    end else begin
      // Push, ack and err are single-cycle pulses.
      push_o  <= 1'b0;
      s_ack_o <= 1'b0;
      s_err_o <= 1'b0;
      case (state)
        US_IDLE: begin
          if (req_take) begin
            push_o <= 1'b1;
            if (s_we_i) begin
              // Posted write, ack together with the push.
              s_ack_o <= 1'b1;
              state   <= US_ACK;
            end else begin
              state <= US_WAIT_RSP;
            end
          end
        end
        US_WAIT_RSP: begin
          // Read finishes with ack or err, never both.
          if (rsp_valid_i) begin
            s_ack_o <= !rsp_err_i;
            s_err_o <= rsp_err_i;
            state   <= US_ACK;
          end
        end
        // Ack or err visible this cycle.
        US_ACK:  state <= US_IDLE;
        default: state <= US_IDLE;
      endcase
    end
  end

  // Entry and read data.
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      push_data_o <= {req_op, s_adr_i, s_dat_i};
    end
    if (state == US_WAIT_RSP && rsp_valid_i) begin
      s_dat_o <= rsp_data_i;
    end
  end

endmodule

//--- source/wb_req_fifo.sv
//************************************************************
// Request FIFO between upstream port and dispatcher.
//************************************************************
`timescale 1ns/1ps

module wb_req_fifo import wb_route_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [REQ_W-1:0] push_data_i,
  input  logic             pop_i,
  output logic             full_o,
  output logic             empty_o,
  output logic [REQ_W-1:0] head_o
);

  logic [REQ_W-1:0]      mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  // Guarded strobes.
  // Pushing when full or popping when empty has no effect.
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count == '0);

  // Head entry, valid while empty_o is low.
  assign head_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Count holds when push and pop meet.
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule

//--- source/wb_dispatch.sv
//************************************************************
// Dispatcher. Pops requests, resolves them and runs one
// Wishbone classic cycle to the selected slave.
//************************************************************
`timescale 1ns/1ps

module wb_dispatch import wb_route_pkg::*; (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // FIFO pop side.
  input  logic                             empty_i,
  input  logic [REQ_W-1:0]                 head_i,
  output logic                             pop_o,
  // Wishbone classic master side.
  output logic [NUM_SLAVE-1:0]             m_cyc_o,
  output logic                             m_stb_o,
  output logic                             m_we_o,
  output logic [ADDR_W-1:0]                m_adr_o,
  output logic [DATA_W-1:0]                m_dat_o,
  input  logic [NUM_SLAVE-1:0]             m_ack_i,
  input  logic [NUM_SLAVE-1:0][DATA_W-1:0] m_dat_i,
  // Read response to the upstream port.
  output logic                             rsp_valid_o,
  output logic                             rsp_err_o,
  output logic [DATA_W-1:0]                rsp_data_o,
  // Sticky unmapped write flag.
  output logic                             wr_decode_err_o
);

  disp_state_e          state;
  wb_op_e               head_op;
  logic [ADDR_W-1:0]    head_adr;
  logic [DATA_W-1:0]    head_dat;
  logic [SLV_IDX_W-1:0] res_idx;
  logic                 res_ok;
  logic [SLV_IDX_W-1:0] sel_idx;
  logic                 take;
  logic                 unmapped_done;
  logic                 slave_ack;

  // Split the head entry.
  assign head_op  = wb_op_e'(head_i[REQ_W-1]);
  assign head_adr = head_i[REQ_W-2 -: ADDR_W];
  assign head_dat = head_i[DATA_W-1:0];

  // Decode the head address.
  wb_addr_resolver u_resolver (
    .addr_i      (head_adr),
    .match_idx_o (res_idx),
    .match_ok_o  (res_ok)
  );

  // Take the head when idle.
  // A pop still pending means the FIFO has not yet moved.
  assign take = (state == DS_IDLE) && !pop_o && !empty_i;

  // Pop of an unmapped request, one cycle ago.
  assign unmapped_done = (state == DS_IDLE) && pop_o;

  // Ack from the selected slave only.
  assign slave_ack = (state == DS_CYCLE) && m_ack_i[sel_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state           <= DS_IDLE;
      pop_o           <= 1'b0;
      m_cyc_o         <= '0;
      m_stb_o         <= 1'b0;
      rsp_valid_o     <= 1'b0;
      wr_decode_err_o <= 1'b0;
    end else begin
      pop_o       <= 1'b0;
      rsp_valid_o <= 1'b0;
      if (take) begin
        pop_o <= 1'b1;
        // Mapped, so start the cycle with the pop.
        if (res_ok) begin
          m_cyc_o <= NUM_SLAVE'(1) << res_idx;
          m_stb_o <= 1'b1;
          state   <= DS_CYCLE;
        end
      end
      if (unmapped_done) begin
        // Write is dropped, read gets an error.
        if (m_we_o) begin
          wr_decode_err_o <= 1'b1;
        end else begin
          rsp_valid_o <= 1'b1;
        end
      end
      if (slave_ack) begin
        m_cyc_o <= '0;
        m_stb_o <= 1'b0;
        state   <= DS_IDLE;
        // Writes were acked upstream already.
        rsp_valid_o <= !m_we_o;
      end
    end
  end

  // Request and response payload.
  always_ff @(posedge clk_i) begin
    if (take) begin
      m_we_o  <= (head_op == OP_WRITE);
      m_adr_o <= head_adr;
      m_dat_o <= head_dat;
      sel_idx <= res_idx;
    end
    if (unmapped_done) begin
      rsp_err_o  <= 1'b1;
      rsp_data_o <= '0;
    end
    if (slave_ack) begin
      rsp_err_o  <= 1'b0;
      rsp_data_o <= m_dat_i[sel_idx];
    end
  end

endmodule

//--- source/wb_router_top.sv
//************************************************************
// Wishbone address router top. Port, FIFO and dispatcher.
//************************************************************
`timescale 1ns/1ps

module wb_router_top import wb_route_pkg::*; (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // Upstream, from the master.
  input  logic                             s_cyc_i,
  input  logic                             s_stb_i,
  input  logic                             s_we_i,
  input  logic [ADDR_W-1:0]                s_adr_i,
  input  logic [DATA_W-1:0]                s_dat_i,
  output logic                             s_ack_o,
  output logic                             s_err_o,
  output logic [DATA_W-1:0]                s_dat_o,
  // Downstream, to the slaves.
  output logic [NUM_SLAVE-1:0]             m_cyc_o,
  output logic                             m_stb_o,
  output logic                             m_we_o,
  output logic [ADDR_W-1:0]                m_adr_o,
  output logic [DATA_W-1:0]                m_dat_o,
  input  logic [NUM_SLAVE-1:0]             m_ack_i,
  input  logic [NUM_SLAVE-1:0][DATA_W-1:0] m_dat_i,
  // Status.
  output logic                             wr_decode_err_o
);

  // Port to FIFO.
  logic              push;
  logic [REQ_W-1:0]  push_data;
  logic              full;
  // FIFO to dispatcher.
  logic              pop;
  logic              empty;
  logic [REQ_W-1:0]  head;
  // Read response back to the port.
  logic              rsp_valid;
  logic              rsp_err;
  logic [DATA_W-1:0] rsp_data;

  wb_upstream_port u_port (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .s_cyc_i     (s_cyc_i),
    .s_stb_i     (s_stb_i),
    .s_we_i      (s_we_i),
    .s_adr_i     (s_adr_i),
    .s_dat_i     (s_dat_i),
    .s_ack_o     (s_ack_o),
    .s_err_o     (s_err_o),
    .s_dat_o     (s_dat_o),
    .push_o      (push),
    .push_data_o (push_data),
    .full_i      (full),
    .rsp_valid_i (rsp_valid),
    .rsp_err_i   (rsp_err),
    .rsp_data_i  (rsp_data)
  );

  wb_req_fifo u_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .full_o      (full),
    .empty_o     (empty),
    .head_o      (head)
  );

  wb_dispatch u_disp (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .empty_i         (empty),
    .head_i          (head),
    .pop_o           (pop),
    .m_cyc_o         (m_cyc_o),
    .m_stb_o         (m_stb_o),
    .m_we_o          (m_we_o),
    .m_adr_o         (m_adr_o),
    .m_dat_o         (m_dat_o),
    .m_ack_i         (m_ack_i),
    .m_dat_i         (m_dat_i),
    .rsp_valid_o     (rsp_valid),
    .rsp_err_o       (rsp_err),
    .rsp_data_o      (rsp_data),
    .wr_decode_err_o (wr_decode_err_o)
  );

endmodule

//--- verif/wb_router_props.sv
//************************************************************
// Router assertions on the dispatcher and its resolver.
//************************************************************
`timescale 1ns/1ps

module wb_router_props import wb_route_pkg::*; (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 empty_i,
  input logic [NUM_SLAVE-1:0] slave_hit_i,
  input logic [NUM_SLAVE-1:0] m_cyc_i,
  input logic                 m_stb_i,
  input logic                 rsp_valid_i
);

  // A valid head address hits one slave at most.
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    !empty_i |-> $onehot0(slave_hit_i))
    else $error("Resolver hit more than one slave");

  // Only one downstream slave is selected.
  a_cyc_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(m_cyc_i))
    else $error("More than one m_cyc_o bit high");

  // Strobe only inside a cycle.
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    m_stb_i |-> |m_cyc_i)
    else $error("m_stb_o high without m_cyc_o");

  // Read response is a single pulse.
  a_rsp_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("rsp_valid held for more than one cycle");

endmodule

bind wb_dispatch wb_router_props u_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .empty_i     (empty_i),
  .slave_hit_i (u_resolver.slave_hit),
  .m_cyc_i     (m_cyc_o),
  .m_stb_i     (m_stb_o),
  .rsp_valid_i (rsp_valid_o)
);

//--- verif/wb_router_tb.sv
//************************************************************
// Router testbench. Upstream master, three slave memories,
// a cycle monitor and the directed tests.
//************************************************************
`timescale 1ns/1ps

module wb_router_tb import wb_route_pkg::*; ();

  logic                             clk_i;
  logic                             reset_i;
  logic                             s_cyc_i;
  logic                             s_stb_i;
  logic                             s_we_i;
  logic [ADDR_W-1:0]                s_adr_i;
  logic [DATA_W-1:0]                s_dat_i;
  logic                             s_ack_o;
  logic                             s_err_o;
  logic [DATA_W-1:0]                s_dat_o;
  logic [NUM_SLAVE-1:0]             m_cyc_o;
  logic                             m_stb_o;
  logic                             m_we_o;
  logic [ADDR_W-1:0]                m_adr_o;
  logic [DATA_W-1:0]                m_dat_o;
  logic [NUM_SLAVE-1:0]             m_ack_i = '0;
  logic [NUM_SLAVE-1:0][DATA_W-1:0] m_dat_i = '0;
  logic                             wr_decode_err_o;

  // Slave memories and their wait state counters.
  logic [DATA_W-1:0]          mem [NUM_SLAVE][2**ADDR_W];
  int                         wait_left [NUM_SLAVE];
  int                         wait_seed = 31;
  int                         seed = 31;
  logic [NUM_SLAVE-1:0]       stall;
  // Per-slave cycle monitor and memory write counts.
  logic [NUM_SLAVE-1:0]       cyc_q;
  logic [NUM_SLAVE-1:0][15:0] cyc_cnt = '0;
  logic [NUM_SLAVE-1:0][15:0] wr_cnt = '0;
  int                         err_cnt = 0;
  int                         to_cnt = 0;

  wb_router_top u_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .s_cyc_i         (s_cyc_i),
    .s_stb_i         (s_stb_i),
    .s_we_i          (s_we_i),
    .s_adr_i         (s_adr_i),
    .s_dat_i         (s_dat_i),
    .s_ack_o         (s_ack_o),
    .s_err_o         (s_err_o),
    .s_dat_o         (s_dat_o),
    .m_cyc_o         (m_cyc_o),
    .m_stb_o         (m_stb_o),
    .m_we_o          (m_we_o),
    .m_adr_o         (m_adr_o),
    .m_dat_o         (m_dat_o),
    .m_ack_i         (m_ack_i),
    .m_dat_i         (m_dat_i),
    .wr_decode_err_o (wr_decode_err_o)
  );

  // 20 ns clock.
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Slave models.
  // Ack after 0 to 3 wait cycles and never while stalled.
  always @(posedge clk_i) begin
    for (int s = 0; s < NUM_SLAVE; s++) begin
      m_ack_i[s] <= 1'b0;
      if (reset_i) begin
        wait_left[s] = 0;
        wr_cnt[s] <= '0;
      end else if (m_cyc_o[s] && m_stb_o && !m_ack_i[s] && !stall[s]) begin
        if (wait_left[s] == 0) begin
          m_ack_i[s] <= 1'b1;
          if (m_we_o) begin
            mem[s][m_adr_o] = m_dat_o;
            wr_cnt[s] <= wr_cnt[s] + 16'd1;
          end else begin
            m_dat_i[s] <= mem[s][m_adr_o];
          end
          // Wait states for the next cycle on this slave.
          wait_left[s] = $random(wait_seed) & 3;
        end else begin
          wait_left[s] = wait_left[s] - 1;
        end
      end
    end
  end

  // Cycle monitor counts rising m_cyc_o bits.
  always @(posedge clk_i) begin
    cyc_q <= m_cyc_o;
    for (int s = 0; s < NUM_SLAVE; s++) begin
      if (reset_i) begin
        cyc_cnt[s] <= '0;
      end else if (m_cyc_o[s] && !cyc_q[s]) begin
        cyc_cnt[s] <= cyc_cnt[s] + 16'd1;
      end
    end
  end

  // Reference decoder written from the address map.
  function automatic int ref_slave(input logic [ADDR_W-1:0] adr);
    if (adr <= 16'h1FFF) return 0;
    if (adr >= 16'h4000 && adr <= 16'h7FFF) return 1;
    if (adr >= 16'h2000 && adr <= 16'h2FFF) return 1;
    if (adr >= 16'h8000 && adr <= 16'hCFFF) return 2;
    return -1;
  endfunction

  task automatic report_value(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    err_cnt++;
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
  endtask

  // Master drives a request and holds it.
  task automatic start_req(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] wdat);
    @(posedge clk_i);
    s_cyc_i <= 1'b1;
    s_stb_i <= 1'b1;
    s_we_i  <= we;
    s_adr_i <= adr;
    s_dat_i <= wdat;
  endtask

  // Wait for ack or err for at most max_cyc cycles.
  task automatic wait_resp(input int max_cyc, output logic ack, output logic err,
                           output logic [DATA_W-1:0] rdat);
    int n;
    ack  = 1'b0;
    err  = 1'b0;
    rdat = '0;
    n    = 0;
    while (!ack && !err && n < max_cyc) begin
      @(posedge clk_i);
      ack  = s_ack_o;
      err  = s_err_o;
      rdat = s_dat_o;
      n++;
    end
  endtask

  task automatic end_req();
    s_cyc_i <= 1'b0;
    s_stb_i <= 1'b0;
  endtask

  // One full upstream access.
  task automatic access(input logic we, input logic [ADDR_W-1:0] adr,
                        input logic [DATA_W-1:0] wdat, output logic ack,
                        output logic err, output logic [DATA_W-1:0] rdat);
    start_req(we, adr, wdat);
    wait_resp(200, ack, err, rdat);
    end_req();
    if (!ack && !err) begin
      to_cnt++;
      $display("Timeout: no s_ack_o or s_err_o for access at 0x%04h", adr);
    end
  endtask

  // Write then read one address. Only exp_slv may see cycles.
  task automatic route_write_read(input logic [ADDR_W-1:0] adr, input int exp_slv);
    logic [NUM_SLAVE-1:0][15:0] cyc0;
    logic [NUM_SLAVE-1:0][15:0] wr0;
    logic [15:0]                exp_cyc;
    logic [15:0]                exp_wr;
    logic [DATA_W-1:0]          wdat;
    logic [DATA_W-1:0]          rdat;
    logic                       ack;
    logic                       err;
    cyc0 = cyc_cnt;
    wr0  = wr_cnt;
    wdat = {16'hC0DE, adr};
    access(1'b1, adr, wdat, ack, err, rdat);
    access(1'b0, adr, '0, ack, err, rdat);
    if (rdat !== wdat) begin
      report_value($sformatf("s_dat_o at 0x%04h", adr), rdat, wdat);
    end
    for (int s = 0; s < NUM_SLAVE; s++) begin
      exp_cyc = (s == exp_slv) ? cyc0[s] + 16'd2 : cyc0[s];
      exp_wr  = (s == exp_slv) ? wr0[s] + 16'd1 : wr0[s];
      if (cyc_cnt[s] !== exp_cyc) begin
        report_value($sformatf("cyc_cnt[%0d]", s), DATA_W'(cyc_cnt[s]), DATA_W'(exp_cyc));
      end
      if (wr_cnt[s] !== exp_wr) begin
        report_value($sformatf("wr_cnt[%0d]", s), DATA_W'(wr_cnt[s]), DATA_W'(exp_wr));
      end
    end
  endtask

  task automatic read_unmapped(input logic [ADDR_W-1:0] adr);
    logic [NUM_SLAVE-1:0][15:0] cyc0;
    logic [DATA_W-1:0]          rdat;
    logic                       ack;
    logic                       err;
    cyc0 = cyc_cnt;
    access(1'b0, adr, '0, ack, err, rdat);
    if (err !== 1'b1) begin
      report_value($sformatf("s_err_o at 0x%04h", adr), DATA_W'(err), 1);
    end
    if (ack !== 1'b0) begin
      report_value($sformatf("s_ack_o at 0x%04h", adr), DATA_W'(ack), 0);
    end
    for (int s = 0; s < NUM_SLAVE; s++) begin
      if (cyc_cnt[s] !== cyc0[s]) begin
        report_value($sformatf("cyc_cnt[%0d]", s), DATA_W'(cyc_cnt[s]), DATA_W'(cyc0[s]));
      end
    end
  endtask

  // The dropped write must raise the sticky flag.
  task automatic drop_unmapped_write();
    logic [NUM_SLAVE-1:0][15:0] wr0;
    logic [DATA_W-1:0]          rdat;
    logic                       ack;
    logic                       err;
    int                         n;
    if (wr_decode_err_o !== 1'b0) begin
      report_value("wr_decode_err_o before write", DATA_W'(wr_decode_err_o), 0);
    end
    wr0 = wr_cnt;
    access(1'b1, 16'hD100, 32'h0BAD_D100, ack, err, rdat);
    if (ack !== 1'b1) begin
      report_value("s_ack_o at 0xd100", DATA_W'(ack), 1);
    end
    n = 0;
    while (wr_decode_err_o !== 1'b1 && n < 50) begin
      @(posedge clk_i);
      n++;
    end
    if (wr_decode_err_o !== 1'b1) begin
      to_cnt++;
      $display("Timeout: wr_decode_err_o never rose after the unmapped write");
    end
    for (int s = 0; s < NUM_SLAVE; s++) begin
      if (wr_cnt[s] !== wr0[s]) begin
        report_value($sformatf("wr_cnt[%0d]", s), DATA_W'(wr_cnt[s]), DATA_W'(wr0[s]));
      end
    end
  endtask

  // Six writes behind a stalled slave 1.
  // The FIFO plus the open cycle bound the posted writes.
  task automatic stall_backpressure();
    logic [DATA_W-1:0] rdat;
    logic              ack;
    logic              err;
    int                acked;
    int                held;
    acked = 0;
    held  = 0;
    @(posedge clk_i);
    stall[1] <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      start_req(1'b1, 16'h4440, 32'hB000_0000 + DATA_W'(i));
      wait_resp(30, ack, err, rdat);
      if (!ack && !err && held == 0) begin
        // Held off. Release slave 1 so the FIFO drains.
        held = i + 1;
        stall[1] <= 1'b0;
        wait_resp(200, ack, err, rdat);
      end else if (ack && held == 0) begin
        acked++;
      end
      end_req();
      if (!ack) begin
        to_cnt++;
        $display("Timeout: write %0d to slave 1 got no ack", i);
      end
    end
    stall[1] <= 1'b0;
    if (held == 0) begin
      err_cnt++;
      $display("No write was held back while slave 1 was stalled");
    end
    if (acked != FIFO_DEPTH + 1) begin
      err_cnt++;
      $display("Wrong number of writes acked while slave 1 was stalled: %0d instead of %0d",
               acked, FIFO_DEPTH + 1);
    end
    access(1'b0, 16'h4440, '0, ack, err, rdat);
    if (rdat !== 32'hB000_0005) begin
      report_value("s_dat_o at 0x4440", rdat, 32'hB000_0005);
    end
  endtask

  // Forty random writes and then forty reads against the scoreboard.
  task automatic random_traffic();
    logic [ADDR_W-1:0]          adrs [40];
    logic [DATA_W-1:0]          sb [int];
    int                         exp_cyc [NUM_SLAVE];
    logic [ADDR_W-1:0]          adr;
    logic [DATA_W-1:0]          wdat;
    logic [DATA_W-1:0]          rdat;
    logic                       ack;
    logic                       err;
    int                         slv;
    int                         tries;
    for (int s = 0; s < NUM_SLAVE; s++) begin
      exp_cyc[s] = int'(cyc_cnt[s]);
    end
    for (int i = 0; i < 40; i++) begin
      adr   = ADDR_W'($random(seed));
      tries = 0;
      while (ref_slave(adr) < 0 && tries < 100) begin
        adr = ADDR_W'($random(seed));
        tries++;
      end
      slv     = ref_slave(adr);
      wdat    = $random(seed);
      adrs[i] = adr;
      sb[slv * (2**ADDR_W) + int'(adr)] = wdat;
      // One write and one read cycle on the decoded slave.
      exp_cyc[slv] += 2;
      access(1'b1, adr, wdat, ack, err, rdat);
    end
    for (int i = 0; i < 40; i++) begin
      slv = ref_slave(adrs[i]);
      access(1'b0, adrs[i], '0, ack, err, rdat);
      if (rdat !== sb[slv * (2**ADDR_W) + int'(adrs[i])]) begin
        report_value($sformatf("s_dat_o at 0x%04h", adrs[i]), rdat,
                     sb[slv * (2**ADDR_W) + int'(adrs[i])]);
      end
    end
    for (int s = 0; s < NUM_SLAVE; s++) begin
      if (cyc_cnt[s] !== 16'(exp_cyc[s])) begin
        report_value($sformatf("cyc_cnt[%0d]", s), DATA_W'(cyc_cnt[s]), DATA_W'(exp_cyc[s]));
      end
    end
  endtask

  initial begin
    reset_i <= 1'b1;
    s_cyc_i <= 1'b0;
    s_stb_i <= 1'b0;
    s_we_i  <= 1'b0;
    s_adr_i <= '0;
    s_dat_i <= '0;
    stall   <= '0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    // Idle outputs after reset.
    if ({s_ack_o, s_err_o, m_cyc_o, m_stb_o, wr_decode_err_o} !== '0) begin
      report_value("outputs after reset", DATA_W'({s_ack_o, s_err_o, m_cyc_o, m_stb_o,
                   wr_decode_err_o}), 0);
    end
    if (u_dut.u_fifo.empty_o !== 1'b1) begin
      report_value("empty_o after reset", DATA_W'(u_dut.u_fifo.empty_o), 1);
    end
    route_write_read(16'h0123, 0);
    route_write_read(16'h5ABC, 1);
    route_write_read(16'h9004, 2);
    route_write_read(16'h1ABC, 0);
    route_write_read(16'h2DEF, 1);
    route_write_read(16'hC123, 2);
    read_unmapped(16'h3000);
    read_unmapped(16'hE000);
    drop_unmapped_write();
    stall_backpressure();
    random_traffic();
    // Sticky flag survives all later traffic.
    if (wr_decode_err_o !== 1'b1) begin
      report_value("wr_decode_err_o at end", DATA_W'(wr_decode_err_o), 1);
    end
    $display("Checks done: %0d value errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
source/wb_route_pkg.sv
source/wb_addr_resolver.sv
source/wb_upstream_port.sv
source/wb_req_fifo.sv
source/wb_dispatch.sv
source/wb_router_top.sv
verif/wb_router_props.sv
verif/wb_router_tb.sv

//--- Makefile
SIM  := obj_dir/Vwb_router_tb
SRCS := $(wildcard source/*.sv verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module wb_router_tb

# The log decides the result.
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
